// ==== verilog/mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// data word and memory size
`define DATA_WIDTH  32
`define DATA_BYTES  (`DATA_WIDTH / 8)
`define RAM_DEPTH   256

// tlb geometry
`define TLB_ENTRIES 4
`define PAGE_BITS   12
`define VPPN_WIDTH  (32 - `PAGE_BITS)

`endif

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    typedef enum logic [3:0] {
        NOP   = 4'd0,
        LD_B  = 4'd1,
        LD_BU = 4'd2,
        LD_H  = 4'd3,
        LD_HU = 4'd4,
        LD_W  = 4'd5,
        ST_B  = 4'd6,
        ST_H  = 4'd7,
        ST_W  = 4'd8,
        LL    = 4'd9,
        SC    = 4'd10
    } mem_op_e;

    // ale is the msb of the vector
    typedef struct packed {
        logic ale;
        logic tlbr;
        logic pil;
        logic pis;
        logic ppi;
        logic pme;
    } excp_vec_t;

    typedef struct packed {
        logic [31:0] paddr;
        excp_vec_t   excp;
    } addr_result_t;

    function automatic logic is_load(mem_op_e op);
        return op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, LL};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {ST_B, ST_H, ST_W, SC};
    endfunction

    function automatic logic is_half(mem_op_e op);
        return op inside {LD_H, LD_HU, ST_H};
    endfunction

    function automatic logic is_word(mem_op_e op);
        return op inside {LD_W, ST_W, LL, SC};
    endfunction

endpackage

// ==== verilog/csr_pkg.sv ====
package csr_pkg;

    typedef logic [1:0] plv_t;

    localparam plv_t PLV_KERNEL = 2'd0;
    localparam plv_t PLV_USER   = 2'd3;

    // direct mapped window register layout
    typedef struct packed {
        logic [2:0]  vseg;
        logic        rsvd_28;
        logic [2:0]  pseg;
        logic [20:0] rsvd_24_4;
        logic        plv3;
        logic [1:0]  rsvd_2_1;
        logic        plv0;
    } dmw_t;

    typedef struct packed {
        plv_t plv;
        logic da;
        logic pg;
        dmw_t dmw0;
        dmw_t dmw1;
    } csr_mem_t;

endpackage

// ==== verilog/mem_if.sv ====
`timescale 1ns/1ps

`include "mem_settings.svh"

interface data_bus_if;
    logic                   ce;
    logic                   we;
    logic [`DATA_BYTES-1:0] sel;
    logic [31:0]            paddr;
    logic [`DATA_WIDTH-1:0] wdata;
    logic [`DATA_WIDTH-1:0] rdata;

    modport master (output ce, output we, output sel, output paddr, output wdata, input rdata);
    modport slave (input ce, input we, input sel, input paddr, input wdata, output rdata);
endinterface

interface tlb_lookup_if
    import csr_pkg::*;
();
    logic [`VPPN_WIDTH-1:0] vppn;
    logic                   found;
    logic                   v;
    logic                   d;
    plv_t                   plv;
    logic [`VPPN_WIDTH-1:0] ppn;

    modport master (output vppn, input found, input v, input d, input plv, input ppn);
    modport slave (input vppn, output found, output v, output d, output plv, output ppn);
endinterface

// ==== verilog/data_ram.sv ====
`timescale 1ns/1ps

`include "mem_settings.svh"

module data_ram (
    input logic       clk,
    data_bus_if.slave bus
);

    localparam int AW = $clog2(`RAM_DEPTH);

    logic [`DATA_WIDTH-1:0] mem [`RAM_DEPTH] = '{default: '0};
    logic [AW-1:0]          word_addr;

    assign word_addr = bus.paddr[AW+1:2];

    // sel[3] is the byte at bits 31:24
    always_ff @(posedge clk) begin
        if (bus.ce) begin
            if (bus.we) begin
                for (int b = 0; b < `DATA_BYTES; b++) begin
                    if (bus.sel[b]) begin
                        mem[word_addr][8*b +: 8] <= bus.wdata[8*b +: 8];
                    end
                end
            end else begin
                bus.rdata <= mem[word_addr];
            end
        end
    end

endmodule

// ==== verilog/data_tlb.sv ====
`timescale 1ns/1ps

`include "mem_settings.svh"

module data_tlb
    import csr_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            we_i,
    input  logic [$clog2(`TLB_ENTRIES)-1:0] index_i,
    input  logic [`VPPN_WIDTH-1:0]          vppn_i,
    input  logic [`VPPN_WIDTH-1:0]          ppn_i,
    input  plv_t                            plv_i,
    input  logic                            v_i,
    input  logic                            d_i,
    tlb_lookup_if.slave                     lookup
);

    logic [`TLB_ENTRIES-1:0] present;
    logic [`VPPN_WIDTH-1:0]  vppn_q [`TLB_ENTRIES];
    logic [`VPPN_WIDTH-1:0]  ppn_q  [`TLB_ENTRIES];
    plv_t                    plv_q  [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] v_q;
    logic [`TLB_ENTRIES-1:0] d_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            present <= '0;
        end else if (we_i) begin
            present[index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            vppn_q[index_i] <= vppn_i;
            ppn_q[index_i]  <= ppn_i;
            plv_q[index_i]  <= plv_i;
            v_q[index_i]    <= v_i;
            d_q[index_i]    <= d_i;
        end
    end

    // scan downwards so the lowest matching index wins
    always_comb begin
        lookup.found = 1'b0;
        lookup.v     = 1'b0;
        lookup.d     = 1'b0;
        lookup.plv   = '0;
        lookup.ppn   = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (present[i] && vppn_q[i] == lookup.vppn) begin
                lookup.found = 1'b1;
                lookup.v     = v_q[i];
                lookup.d     = d_q[i];
                lookup.plv   = plv_q[i];
                lookup.ppn   = ppn_q[i];
            end
        end
    end

endmodule

// ==== verilog/data_addr_check.sv ====
`timescale 1ns/1ps

`include "mem_settings.svh"

module data_addr_check
    import mem_pkg::*;
    import csr_pkg::*;
(
    input  mem_op_e      op_i,
    input  logic [31:0]  vaddr_i,
    input  csr_mem_t     csr_i,
    tlb_lookup_if.master tlb,
    output addr_result_t addr_o
);

    logic pg_mode;
    logic dmw0_hit;
    logic dmw1_hit;
    logic use_tlb;
    logic load_op;
    logic store_op;
    logic access;
    logic entry_ok;

    function automatic logic dmw_hit(dmw_t dmw, plv_t plv, logic [2:0] vseg);
        return ((dmw.plv0 && plv == PLV_KERNEL) || (dmw.plv3 && plv == PLV_USER))
            && dmw.vseg == vseg;
    endfunction

    assign pg_mode  = csr_i.pg && !csr_i.da;
    assign dmw0_hit = dmw_hit(csr_i.dmw0, csr_i.plv, vaddr_i[31:29]);
    assign dmw1_hit = dmw_hit(csr_i.dmw1, csr_i.plv, vaddr_i[31:29]);
    assign use_tlb  = pg_mode && !dmw0_hit && !dmw1_hit;

    assign load_op  = is_load(op_i);
    assign store_op = is_store(op_i);
    assign access   = load_op || store_op;

    assign tlb.vppn = vaddr_i[31:`PAGE_BITS];

    // entry present and valid
    assign entry_ok = use_tlb && tlb.found && tlb.v;

    always_comb begin
        addr_o.excp.ale  = (is_half(op_i) && vaddr_i[0])
                        || (is_word(op_i) && vaddr_i[1:0] != 2'b00);
        addr_o.excp.tlbr = use_tlb && access && !tlb.found;
        addr_o.excp.pil  = use_tlb && load_op && tlb.found && !tlb.v;
        addr_o.excp.pis  = use_tlb && store_op && tlb.found && !tlb.v;
        addr_o.excp.ppi  = entry_ok && access && csr_i.plv > tlb.plv;
        addr_o.excp.pme  = entry_ok && store_op && csr_i.plv <= tlb.plv && !tlb.d;

        if (!pg_mode) begin
            addr_o.paddr = vaddr_i;
        end else if (dmw0_hit) begin
            addr_o.paddr = {csr_i.dmw0.pseg, vaddr_i[28:0]};
        end else if (dmw1_hit) begin
            addr_o.paddr = {csr_i.dmw1.pseg, vaddr_i[28:0]};
        end else begin
            addr_o.paddr = {tlb.ppn, vaddr_i[`PAGE_BITS-1:0]};
        end
    end

endmodule

// ==== verilog/mem_access.sv ====
`timescale 1ns/1ps

`include "mem_settings.svh"

module mem_access
    import mem_pkg::*;
    import csr_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  mem_op_e                op_i,
    input  logic [31:0]            vaddr_i,
    input  logic [`DATA_WIDTH-1:0] store_data_i,
    input  csr_mem_t               csr_i,
    tlb_lookup_if.master           tlb,
    data_bus_if.master             bus,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output logic [`DATA_WIDTH-1:0] result_o,
    output logic                   wreg_o,
    output excp_vec_t              excp_o
);

    addr_result_t           addr;
    logic                   ready_en;
    logic                   accept;
    logic                   advance;
    logic                   has_excp;
    logic                   is_ld;
    logic                   is_st;
    logic                   link;
    logic [1:0]             off;
    logic [`DATA_BYTES-1:0] sel;
    logic [`DATA_WIDTH-1:0] wdata;
    logic [`DATA_WIDTH-1:0] issue_data;
    logic                   issue_wreg;

    // issue slot
    logic                   s1_valid;
    mem_op_e                s1_op;
    logic [1:0]             s1_off;
    excp_vec_t              s1_excp;
    logic [`DATA_WIDTH-1:0] s1_data;
    logic                   s1_wreg;

    logic [7:0]             byte_lane;
    logic [15:0]            half_lane;
    logic [`DATA_WIDTH-1:0] result_d;

    data_addr_check u_addr_check (
        .op_i   (op_i),
        .vaddr_i(vaddr_i),
        .csr_i  (csr_i),
        .tlb    (tlb),
        .addr_o (addr)
    );

    assign off      = vaddr_i[1:0];
    assign has_excp = |addr.excp;
    assign is_ld    = is_load(op_i);
    assign is_st    = is_store(op_i);

    // result slot free, or draining this edge
    assign advance    = s1_valid && (!out_valid_o || out_ready_i);
    assign in_ready_o = ready_en && (!s1_valid || advance);
    assign accept     = in_valid_i && in_ready_o;

    always_comb begin
        if (is_word(op_i)) begin
            sel = 4'b1111;
        end else if (is_half(op_i)) begin
            sel = off[1] ? 4'b0011 : 4'b1100;
        end else begin
            sel = 4'b1000 >> off;
        end
        case (op_i)
            ST_B:    wdata = {4{store_data_i[7:0]}};
            ST_H:    wdata = {2{store_data_i[15:0]}};
            default: wdata = store_data_i;
        endcase
    end

    // sc without the link bit never reaches the ram
    assign bus.ce    = accept && (is_ld || is_st) && !has_excp && (op_i != SC || link);
    assign bus.we    = is_st;
    assign bus.sel   = sel;
    assign bus.paddr = addr.paddr;
    assign bus.wdata = wdata;

    always_comb begin
        issue_wreg = !has_excp && ((is_ld && op_i != LL) || op_i == SC);
        if (has_excp) begin
            // faulting address goes out as result
            issue_data = vaddr_i;
        end else begin
            case (op_i)
                SC:               issue_data = {{(`DATA_WIDTH-1){1'b0}}, link};
                ST_B, ST_H, ST_W: issue_data = store_data_i;
                default:          issue_data = '0;
            endcase
        end
    end

    always_comb begin
        byte_lane = bus.rdata[{~s1_off, 3'b000} +: 8];
        half_lane = s1_off[1] ? bus.rdata[15:0] : bus.rdata[31:16];
        result_d  = s1_data;
        if (!(|s1_excp)) begin
            case (s1_op)
                LD_B:     result_d = {{(`DATA_WIDTH-8){byte_lane[7]}}, byte_lane};
                LD_BU:    result_d = {{(`DATA_WIDTH-8){1'b0}}, byte_lane};
                LD_H:     result_d = {{(`DATA_WIDTH-16){half_lane[15]}}, half_lane};
                LD_HU:    result_d = {{(`DATA_WIDTH-16){1'b0}}, half_lane};
                LD_W, LL: result_d = bus.rdata;
                default:  result_d = s1_data;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ready_en    <= 1'b0;
            s1_valid    <= 1'b0;
            link        <= 1'b0;
            out_valid_o <= 1'b0;
            wreg_o      <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (accept) begin
                s1_valid <= 1'b1;
            end else if (advance) begin
                s1_valid <= 1'b0;
            end
            if (accept && !has_excp) begin
                if (op_i == LL) begin
                    link <= 1'b1;
                end else if (op_i == SC && link) begin
                    link <= 1'b0;
                end
            end
            if (advance) begin
                out_valid_o <= 1'b1;
                wreg_o      <= s1_wreg;
            end else if (out_ready_i) begin
                out_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_op   <= op_i;
            s1_off  <= off;
            s1_excp <= addr.excp;
            s1_data <= issue_data;
            s1_wreg <= issue_wreg;
        end
        if (advance) begin
            result_o <= result_d;
            excp_o   <= s1_excp;
        end
    end

endmodule

// ==== verilog/mem_stage_top.sv ====
`timescale 1ns/1ps

`include "mem_settings.svh"

module mem_stage_top
    import mem_pkg::*;
    import csr_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  mem_op_e                op_i,
    input  logic [31:0]            vaddr_i,
    input  logic [`DATA_WIDTH-1:0] store_data_i,
    input  plv_t                   plv_i,
    input  logic                   da_i,
    input  logic                   pg_i,
    input  logic [31:0]            dmw0_i,
    input  logic [31:0]            dmw1_i,
    input  logic                   tlb_we_i,
    input  logic [1:0]             tlb_index_i,
    input  logic [19:0]            tlb_vppn_i,
    input  logic [19:0]            tlb_ppn_i,
    input  plv_t                   tlb_plv_i,
    input  logic                   tlb_v_i,
    input  logic                   tlb_d_i,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output logic [`DATA_WIDTH-1:0] result_o,
    output logic                   wreg_o,
    output excp_vec_t              excp_o
);

    csr_mem_t     csr;
    data_bus_if   bus ();
    tlb_lookup_if tlb ();

    assign csr.plv  = plv_i;
    assign csr.da   = da_i;
    assign csr.pg   = pg_i;
    assign csr.dmw0 = dmw_t'(dmw0_i);
    assign csr.dmw1 = dmw_t'(dmw1_i);

    mem_access u_access (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .op_i        (op_i),
        .vaddr_i     (vaddr_i),
        .store_data_i(store_data_i),
        .csr_i       (csr),
        .tlb         (tlb),
        .bus         (bus),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .result_o    (result_o),
        .wreg_o      (wreg_o),
        .excp_o      (excp_o)
    );

    data_tlb u_tlb (
        .clk    (clk),
        .reset_i(reset_i),
        .we_i   (tlb_we_i),
        .index_i(tlb_index_i),
        .vppn_i (tlb_vppn_i),
        .ppn_i  (tlb_ppn_i),
        .plv_i  (tlb_plv_i),
        .v_i    (tlb_v_i),
        .d_i    (tlb_d_i),
        .lookup (tlb)
    );

    data_ram u_ram (
        .clk(clk),
        .bus(bus)
    );

endmodule

// ==== testbench/tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage
    import mem_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        logic [31:0] result;
        logic        wreg;
        logic [5:0]  excp;
        logic [31:0] line_no;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    mem_op_e     op;
    logic [31:0] vaddr;
    logic [31:0] store_data;
    logic [1:0]  plv;
    logic        da;
    logic        pg;
    logic [31:0] dmw0;
    logic [31:0] dmw1;
    logic        tlb_we;
    logic [1:0]  tlb_index;
    logic [19:0] tlb_vppn;
    logic [19:0] tlb_ppn;
    logic [1:0]  tlb_plv;
    logic        tlb_v;
    logic        tlb_d;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] result;
    logic        wreg;
    excp_vec_t   excp;

    integer      seed;
    expect_t     exp_q[$];
    string       name_q[$];
    string       test_name = "none";
    int          sent_count = 0;

    // output state seen at a stalled edge
    logic        held = 1'b0;
    logic [31:0] held_result;
    logic        held_wreg;
    logic [5:0]  held_excp;
    string       held_name = "none";

    mem_stage_top UUT (
        .clk         (clk),
        .reset_i     (reset),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .op_i        (op),
        .vaddr_i     (vaddr),
        .store_data_i(store_data),
        .plv_i       (plv),
        .da_i        (da),
        .pg_i        (pg),
        .dmw0_i      (dmw0),
        .dmw1_i      (dmw1),
        .tlb_we_i    (tlb_we),
        .tlb_index_i (tlb_index),
        .tlb_vppn_i  (tlb_vppn),
        .tlb_ppn_i   (tlb_ppn),
        .tlb_plv_i   (tlb_plv),
        .tlb_v_i     (tlb_v),
        .tlb_d_i     (tlb_d),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .result_o    (result),
        .wreg_o      (wreg),
        .excp_o      (excp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // random back-pressure with ready about three cycles in four
    always @(posedge clk) begin
        #1;
        out_ready = (($random(seed) & 3) != 0);
    end

    task automatic abort_run;
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic bad_line(int line_no);
        $display("line %0d of the stimulus file could not be parsed", line_no);
        abort_run();
    endtask

    function automatic string strip_eol(string s);
        int n;
        n = s.len();
        while (n > 0 && (s.getc(n - 1) == "\n" || s.getc(n - 1) == "\r"
                         || s.getc(n - 1) == " ")) begin
            n--;
        end
        return s.substr(0, n - 1);
    endfunction

    task automatic write_tlb(logic [1:0] idx, logic [19:0] vppn_v, logic [19:0] ppn_v,
                             logic [1:0] plv_v, logic v_v, logic d_v);
        tlb_index = idx;
        tlb_vppn  = vppn_v;
        tlb_ppn   = ppn_v;
        tlb_plv   = plv_v;
        tlb_v     = v_v;
        tlb_d     = d_v;
        tlb_we    = 1'b1;
        @(posedge clk);
        #1;
        tlb_we = 1'b0;
    endtask

    task automatic send_access(logic [3:0] code, logic [31:0] addr, logic [31:0] data,
                               expect_t e);
        int waited;
        waited     = 0;
        op         = mem_op_e'(code);
        vaddr      = addr;
        store_data = data;
        in_valid   = 1'b1;
        @(posedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: request on line %0d was never accepted", e.line_no);
                abort_run();
            end
            @(posedge clk);
        end
        exp_q.push_back(e);
        name_q.push_back(test_name);
        sent_count++;
        #1;
        in_valid = 1'b0;
    endtask

    task automatic check_result;
        expect_t e;
        string   name;
        if (exp_q.size() == 0) begin
            $display("a result came out with no request outstanding");
            abort_run();
        end else begin
            e    = exp_q.pop_front();
            name = name_q.pop_front();
            assert (result == e.result) else begin
                $display("error in %s (line %0d): result expected %08h, actual %08h",
                         name, e.line_no, e.result, result);
                abort_run();
            end
            assert (wreg == e.wreg) else begin
                $display("error in %s (line %0d): wreg expected %0b, actual %0b",
                         name, e.line_no, e.wreg, wreg);
                abort_run();
            end
            assert (excp == e.excp) else begin
                $display("error in %s (line %0d): excp expected %02h, actual %02h",
                         name, e.line_no, e.excp, excp);
                abort_run();
            end
        end
    endtask

    task automatic drain_results;
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: %0d results never came out", exp_q.size());
                abort_run();
            end
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (!reset && held) begin
            assert (result == held_result && wreg == held_wreg && excp == held_excp) else begin
                $display("error in %s: held output expected %08h/%0b/%02h, actual %08h/%0b/%02h",
                         held_name, held_result, held_wreg, held_excp, result, wreg, excp);
                abort_run();
            end
        end
        if (!reset && out_valid && out_ready) begin
            check_result();
        end
        held        = !reset && out_valid && !out_ready;
        held_result = result;
        held_wreg   = wreg;
        held_excp   = excp;
        if (name_q.size() != 0) begin
            held_name = name_q[0];
        end
    end

    initial begin
        int          fd;
        int          line_no;
        int          count;
        byte         kind;
        string       line;
        string       rest;
        logic [31:0] f0, f1, f2, f3, f4, f5;
        expect_t     e;

        seed       = 32'hceec_78d6;
        clk        = 1'b0;
        reset      = 1'b1;
        in_valid   = 1'b0;
        op         = NOP;
        vaddr      = '0;
        store_data = '0;
        plv        = 2'd0;
        da         = 1'b1;
        pg         = 1'b0;
        dmw0       = '0;
        dmw1       = '0;
        tlb_we     = 1'b0;
        tlb_index  = '0;
        tlb_vppn   = '0;
        tlb_ppn    = '0;
        tlb_plv    = '0;
        tlb_v      = 1'b0;
        tlb_d      = 1'b0;
        out_ready  = 1'b0;

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        fd = $fopen("testbench/mem_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file testbench/mem_input.txt");
            abort_run();
        end

        line_no = 0;
        while (!$feof(fd)) begin
            line  = "";
            count = $fgets(line, fd);
            line_no++;
            line = strip_eol(line);
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            kind = line.getc(0);
            rest = line.substr(1, line.len() - 1);
            case (kind)
                "N": test_name = line.substr(2, line.len() - 1);
                "C": begin
                    count = $sscanf(rest, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                    if (count != 5) begin
                        bad_line(line_no);
                    end
                    plv  = f0[1:0];
                    da   = f1[0];
                    pg   = f2[0];
                    dmw0 = f3;
                    dmw1 = f4;
                end
                "T": begin
                    count = $sscanf(rest, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
                    if (count != 6) begin
                        bad_line(line_no);
                    end
                    write_tlb(f0[1:0], f1[19:0], f2[19:0], f3[1:0], f4[0], f5[0]);
                end
                "A": begin
                    count = $sscanf(rest, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
                    if (count != 6) begin
                        bad_line(line_no);
                    end
                    e.result  = f3;
                    e.wreg    = f4[0];
                    e.excp    = f5[5:0];
                    e.line_no = line_no;
                    send_access(f0[3:0], f1, f2, e);
                end
                default: bad_line(line_no);
            endcase
        end
        $fclose(fd);

        drain_results();
        // a few idle cycles to catch stray results
        repeat (4) @(posedge clk);

        if (sent_count > 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "no access requests were sent");
        end
    end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/mem_pkg.sv
verilog/csr_pkg.sv
verilog/mem_if.sv
verilog/data_ram.sv
verilog/data_tlb.sv
verilog/data_addr_check.sv
verilog/mem_access.sv
verilog/mem_stage_top.sv
testbench/tb_mem_stage.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -Mdir obj_dir
TOP       := tb_mem_stage
FILELIST  := sim.f
PASS_MSG  := Test completed successfully

BIN  := obj_dir/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST))) verilog/mem_settings.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== testbench/mem_input.txt ====
# N name | C plv da pg dmw0 dmw1 | T idx vppn ppn plv v d
# A op vaddr wdata result wreg excp (hex; op 1 ld.b 2 ld.bu 3 ld.h 4 ld.hu 5 ld.w 6 st.b 7 st.h 8 st.w 9 ll a sc)
N direct_widths
C 0 1 0 0 0
A 8 00000010 11223344 11223344 0 00
A 6 00000011 000000ab 000000ab 0 00
A 7 00000012 0000cdef 0000cdef 0 00
A 5 00000010 0 11abcdef 1 00
A 1 00000011 0 ffffffab 1 00
A 2 00000011 0 000000ab 1 00
A 3 00000012 0 ffffcdef 1 00
A 4 00000010 0 000011ab 1 00
A 1 00000013 0 ffffffef 1 00
A 2 00000010 0 00000011 1 00
N dmw_windows
C 0 0 1 80000001 a2000008
A 8 80000040 cafef00d cafef00d 0 00
C 3 0 1 80000001 a2000008
A 5 a0000040 0 cafef00d 1 00
A 5 80000040 0 80000040 0 10
C 0 1 0 80000001 a2000008
A 5 00000040 0 cafef00d 1 00
N tlb_exceptions
C 3 0 1 0 0
T 0 00010 00000 3 1 1
T 1 00011 00000 3 0 0
T 2 00012 00000 0 1 1
T 3 00013 00000 3 1 0
A 8 00010080 5a5a5a5a 5a5a5a5a 0 00
A 5 00010080 0 5a5a5a5a 1 00
A 8 00014080 12345678 00014080 0 10
A 5 00011080 0 00011080 0 08
A 8 00011080 12345678 00011080 0 04
A 8 00012080 12345678 00012080 0 02
A 8 00013080 12345678 00013080 0 01
A 5 00013080 0 5a5a5a5a 1 00
N misaligned
C 0 1 0 0 0
A 7 00000081 00001111 00000081 0 20
A 8 00000082 22222222 00000082 0 20
A 3 00000083 0 00000083 0 20
A 5 00000081 0 00000081 0 20
A 5 00000080 0 5a5a5a5a 1 00
N ll_sc
A 9 00000080 0 5a5a5a5a 0 00
A a 00000080 600dbeef 00000001 1 00
A 5 00000080 0 600dbeef 1 00
A a 00000080 deadbeef 00000000 1 00
A 9 00000082 0 00000082 0 20
A a 00000080 deadbeef 00000000 1 00
A 5 00000080 0 600dbeef 1 00
